//--- hw/bx_counter.sv
// Bunch-crossing counter
// Free-running orbit counter from 0 to BX_MAX that reloads the
// trigger-latency preset on resync. A BX0 arriving while the count
// is off the preset raises a sticky alignment error, but only once
// a first resync has armed the check

`default_nettype none

module bx_counter (
  input  logic               clock,
  input  logic               reset,
  input  ttc_pkg::ttc_cmds_t cmds,
  output ttc_pkg::bxn_t      bxn,
  output logic               sync_err
);

  import ttc_pkg::*;

  // Set by the first resync after reset
  logic armed;
  // BX0 seen at the wrong count
  logic bx0_misaligned;

  assign bx0_misaligned = cmds.bx0 && armed && (bxn != BXN_PRESET);

  // --------------------------------------------------
  // Orbit counter
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      bxn <= '0;
    end else if (cmds.resync) begin
      bxn <= BXN_PRESET;
    end else if (bxn == BX_MAX) begin
      // End of orbit
      bxn <= '0;
    end else begin
      bxn <= bxn + bxn_t'(1);
    end
  end

  // --------------------------------------------------
  // Arming and sticky error
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      armed    <= 1'b0;
      sync_err <= 1'b0;
    end else begin
      if (cmds.resync) begin
        armed <= 1'b1;
      end
      // Resync clears, misaligned BX0 sets
      if (cmds.resync) begin
        sync_err <= 1'b0;
      end else if (bx0_misaligned) begin
        sync_err <= 1'b1;
      end
    end
  end

  // Count stays inside one orbit
  a_bxn_range: assert property (
    @(posedge clock) disable iff (reset)
    bxn <= BX_MAX
  ) else $error("bxn beyond last crossing");

endmodule

`default_nettype wire

//--- hw/fmm.sv
// FMM trigger start/stop state machine
// Five states: startup, resync, stop, wait_bx0 and run. Resync
// wins over every other transition. Triggers only pass in run,
// signalled by a registered trig_stop level that is low one cycle
// after the machine sits in run

`default_nettype none

module fmm (
  input  logic               clock,
  input  logic               reset,
  input  ttc_pkg::ttc_cmds_t cmds,
  input  ttc_pkg::fmm_ctrl_t ctrl,
  output logic               trig_stop
);

  typedef enum logic [2:0] {
    ST_STARTUP  = 3'd0,
    ST_RESYNC   = 3'd1,
    ST_STOP     = 3'd2,
    ST_WAIT_BX0 = 3'd3,
    ST_RUN      = 3'd4
  } fmm_state_t;

  fmm_state_t state;

  // Stop request that the ignore bit can mask
  logic stop_req;

  assign stop_req = ctrl.force_stop_trigger && !ctrl.ignore_startstop;

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_STARTUP;
    end else if (cmds.resync) begin
      // Resync restarts the sequence from any state
      state <= ST_RESYNC;
    end else begin
      case (state)
        ST_STARTUP: state <= ST_STOP;
        ST_RESYNC: begin
          // BX0 right behind the resync goes straight to run
          if (cmds.bx0) begin
            state <= ST_RUN;
          end else begin
            state <= ST_WAIT_BX0;
          end
        end
        ST_STOP: begin
          if (!stop_req) begin
            state <= ST_WAIT_BX0;
          end
        end
        ST_WAIT_BX0: begin
          if (cmds.bx0 || ctrl.dont_wait) begin
            state <= ST_RUN;
          end else if (stop_req) begin
            state <= ST_STOP;
          end
        end
        ST_RUN: begin
          if (stop_req) begin
            state <= ST_STOP;
          end
        end
        // Unused encodings fall back to stop
        default: state <= ST_STOP;
      endcase
    end
  end

  // Registered stop level high outside run
  always_ff @(posedge clock) begin
    if (reset) begin
      trig_stop <= 1'b1;
    end else begin
      trig_stop <= (state != ST_RUN);
    end
  end

  // Triggers held off through reset and the startup cycle after it
  a_stop_after_reset: assert property (
    @(posedge clock) ($past(reset) || $past(reset, 2)) |-> trig_stop
  ) else $error("trig_stop low right after reset");

endmodule

`default_nettype wire

//--- hw/l1a_bxn_latch.sv
// L1A crossing latch
// Accepts L1A pulses only while the FMM lets triggers run, tags
// each accepted trigger with the crossing number it arrived in
// and keeps a wrapping count of accepted triggers

`default_nettype none

module l1a_bxn_latch (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                l1a,
  input  ttc_pkg::bxn_t                       bxn,
  input  logic                                trig_stop,
  output ttc_pkg::l1a_tag_t                   tag,
  output logic [ttc_pkg::L1A_COUNT_WIDTH-1:0] l1a_count
);

  import ttc_pkg::*;

  // Trigger passes the FMM gate
  logic accept;
  logic tag_valid;
  bxn_t tag_bxn;

  assign accept = l1a && !trig_stop;

  // --------------------------------------------------
  // Control: valid strobe and accepted count
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      tag_valid <= 1'b0;
      l1a_count <= '0;
    end else begin
      tag_valid <= accept;
      if (accept) begin
        // Wraps at full width
        l1a_count <= l1a_count + 1'b1;
      end
    end
  end

  // Crossing number of the accepted pulse
  always_ff @(posedge clock) begin
    if (accept) begin
      tag_bxn <= bxn;
    end
  end

  assign tag.valid = tag_valid;
  assign tag.bxn   = tag_bxn;

endmodule

`default_nettype wire

//--- hw/ttc_cmd_decoder.sv
// TTC broadcast command decoder
// Compares the strobed command byte against the known codes and
// registers the result together with the L1A line, so every
// downstream block sees aligned one-cycle pulses

`default_nettype none

module ttc_cmd_decoder (
  input  logic               clock,
  input  logic               reset,
  input  logic [7:0]         cmd,
  input  logic               cmd_valid,
  input  logic               l1a_in,
  output ttc_pkg::ttc_cmds_t cmds
);

  import ttc_pkg::*;

  // Raw decode of the current strobe
  logic is_bx0;
  logic is_resync;

  assign is_bx0    = cmd_valid && (cmd == CMD_BX0);
  // BC-reset shares the resync path
  assign is_resync = cmd_valid && ((cmd == CMD_RESYNC) || (cmd == CMD_BCRESET));

  // --------------------------------------------------
  // Output register, one cycle after the inputs
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      cmds <= '0;
    end else begin
      cmds.bx0    <= is_bx0;
      cmds.resync <= is_resync;
      // L1A delayed to stay aligned with the commands
      cmds.l1a    <= l1a_in;
    end
  end

  // Only one broadcast code per strobe
  a_one_cmd: assert property (
    @(posedge clock) disable iff (reset)
    !(cmds.bx0 && cmds.resync)
  ) else $error("bx0 and resync pulsed together");

endmodule

`default_nettype wire

//--- hw/ttc_pkg.sv
// TTC synchronization package
// Broadcast command codes, bunch-crossing constants and the
// packed structs that carry commands, FMM controls and L1A tags
// between the trigger-timing blocks

`default_nettype none

package ttc_pkg;

  // --------------------------------------------------
  // Broadcast command codes
  // --------------------------------------------------
  localparam logic [7:0] CMD_BX0     = 8'h01;
  localparam logic [7:0] CMD_RESYNC  = 8'h04;
  // Bunch-counter reset, handled like a resync
  localparam logic [7:0] CMD_BCRESET = 8'h08;

  // --------------------------------------------------
  // Orbit constants
  // --------------------------------------------------
  localparam int BXN_WIDTH       = 12;
  localparam int L1A_COUNT_WIDTH = 16;

  typedef logic [BXN_WIDTH-1:0] bxn_t;

  // Last crossing of the LHC orbit
  localparam bxn_t BX_MAX     = 12'd3563;
  // Loaded on resync, equal to the trigger latency
  localparam bxn_t BXN_PRESET = 12'd160;

  // Aligned single-cycle command pulses
  typedef struct packed {
    logic bx0;
    logic resync;
    logic l1a;
  } ttc_cmds_t;

  // Static FMM control levels
  typedef struct packed {
    logic ignore_startstop;
    logic force_stop_trigger;
    logic dont_wait;
  } fmm_ctrl_t;

  // Accepted trigger with its crossing number
  typedef struct packed {
    logic valid;
    bxn_t bxn;
  } l1a_tag_t;

endpackage

`default_nettype wire

//--- hw/ttc_sync_top.sv
// TTC synchronization front end
// Decoder feeds aligned command pulses to the bunch-crossing
// counter and the FMM; the FMM level gates the L1A crossing latch

`default_nettype none

module ttc_sync_top (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [7:0]                          cmd,
  input  logic                                cmd_valid,
  input  logic                                l1a_in,
  input  ttc_pkg::fmm_ctrl_t                  ctrl,
  output ttc_pkg::bxn_t                       bxn,
  output logic                                sync_err,
  output logic                                trig_stop,
  output ttc_pkg::l1a_tag_t                   tag,
  output logic [ttc_pkg::L1A_COUNT_WIDTH-1:0] l1a_count
);

  import ttc_pkg::*;

  // Registered command pulses
  ttc_cmds_t cmds;

  ttc_cmd_decoder u_decoder (
    .clock     (clock),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .l1a_in    (l1a_in),
    .cmds      (cmds)
  );

  bx_counter u_bx_counter (
    .clock    (clock),
    .reset    (reset),
    .cmds     (cmds),
    .bxn      (bxn),
    .sync_err (sync_err)
  );

  fmm u_fmm (
    .clock     (clock),
    .reset     (reset),
    .cmds      (cmds),
    .ctrl      (ctrl),
    .trig_stop (trig_stop)
  );

  // Latch sees the same bxn the counter drives out
  l1a_bxn_latch u_latch (
    .clock     (clock),
    .reset     (reset),
    .l1a       (cmds.l1a),
    .bxn       (bxn),
    .trig_stop (trig_stop),
    .tag       (tag),
    .l1a_count (l1a_count)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the TTC sync testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module ttc_sync_tb \
  -f ttc_sync_top.f -o ttc_sync_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/ttc_sync_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; } \
  || grep -q "TEST PASS" sim.log \
  || { echo "Simulation gave no result"; exit 1; }
exit 0

//--- ttc_sync_top.f
hw/ttc_pkg.sv
hw/ttc_cmd_decoder.sv
hw/bx_counter.sv
hw/fmm.sv
hw/l1a_bxn_latch.sv
hw/ttc_sync_top.sv
verification/ttc_sync_tb.sv

//--- verification/ttc_sync_tb.sv
// TTC synchronization testbench
// Drives random broadcast commands, L1As and FMM controls into the
// front end and checks every output against a cycle model each cycle

`default_nettype none

module ttc_sync_tb;

  import ttc_pkg::*;

  logic                       clock;
  logic                       reset;
  logic [7:0]                 cmd;
  logic                       cmd_valid;
  logic                       l1a_in;
  fmm_ctrl_t                  ctrl;
  bxn_t                       bxn;
  logic                       sync_err;
  logic                       trig_stop;
  l1a_tag_t                   tag;
  logic [L1A_COUNT_WIDTH-1:0] l1a_count;

  ttc_sync_top dut (
    .clock     (clock),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .l1a_in    (l1a_in),
    .ctrl      (ctrl),
    .bxn       (bxn),
    .sync_err  (sync_err),
    .trig_stop (trig_stop),
    .tag       (tag),
    .l1a_count (l1a_count)
  );

  typedef enum logic [2:0] {M_STARTUP, M_RESYNC, M_STOP, M_WAIT, M_RUN} model_state_t;

  // Model copies of the decoder pulses and all registered state
  logic                       d_bx0;
  logic                       d_resync;
  logic                       d_l1a;
  bxn_t                       m_bxn;
  logic                       m_armed;
  logic                       m_err;
  model_state_t               m_state;
  logic                       m_stop;
  logic                       m_tag_valid;
  bxn_t                       m_tag_bxn;
  logic [L1A_COUNT_WIDTH-1:0] m_count;

  logic [31:0] lfsr = 32'd95122;
  fmm_ctrl_t   ctrl_set;
  int          checks;
  int          errors;
  int          tests_run;
  int          tests_failed;
  // Cycle budget of each test, in order
  int          budget[5] = '{3720, 400, 500, 700, 500};

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // --------------------------------------------------
  // Random source and checking
  // --------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Mostly valid codes, some junk bytes
  function automatic logic [7:0] pick_code();
    logic [2:0] r;
    logic [7:0] b;
    r = 3'(take_bits(3));
    case (r)
      3'd0, 3'd1: b = CMD_BX0;
      3'd2, 3'd3: b = CMD_RESYNC;
      3'd4:       b = CMD_BCRESET;
      default: begin
        b = 8'(take_bits(8));
        if (b == CMD_BX0 || b == CMD_RESYNC || b == CMD_BCRESET) begin
          b = 8'hA5;
        end
      end
    endcase
    return b;
  endfunction

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at time %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Cycle model, called at each rising edge
  // --------------------------------------------------
  task automatic model_step();
    logic         n_bx0;
    logic         n_resync;
    logic         stop_req;
    model_state_t n_state;
    if (reset) begin
      d_bx0       = 1'b0;
      d_resync    = 1'b0;
      d_l1a       = 1'b0;
      m_bxn       = '0;
      m_armed     = 1'b0;
      m_err       = 1'b0;
      m_state     = M_STARTUP;
      m_stop      = 1'b1;
      m_tag_valid = 1'b0;
      m_count     = '0;
    end else begin
      n_bx0    = cmd_valid && (cmd == CMD_BX0);
      n_resync = cmd_valid && (cmd == CMD_RESYNC || cmd == CMD_BCRESET);
      // Latch sees the present stop level and count
      m_tag_valid = d_l1a && !m_stop;
      if (m_tag_valid) begin
        m_tag_bxn = m_bxn;
        m_count   = m_count + L1A_COUNT_WIDTH'(1);
      end
      // Sticky error, checked against the present count
      if (d_resync) begin
        m_err = 1'b0;
      end else if (d_bx0 && m_armed && m_bxn != BXN_PRESET) begin
        m_err = 1'b1;
      end
      if (d_resync) begin
        m_armed = 1'b1;
      end
      if (d_resync) begin
        m_bxn = BXN_PRESET;
      end else if (m_bxn == BX_MAX) begin
        m_bxn = '0;
      end else begin
        m_bxn = m_bxn + 12'd1;
      end
      // FMM with resync priority
      stop_req = ctrl.force_stop_trigger && !ctrl.ignore_startstop;
      n_state  = m_state;
      if (d_resync) begin
        n_state = M_RESYNC;
      end else begin
        case (m_state)
          M_STARTUP: n_state = M_STOP;
          M_RESYNC: begin
            if (d_bx0) n_state = M_RUN;
            else n_state = M_WAIT;
          end
          M_STOP: begin
            if (!stop_req) n_state = M_WAIT;
          end
          M_WAIT: begin
            if (d_bx0 || ctrl.dont_wait) n_state = M_RUN;
            else if (stop_req) n_state = M_STOP;
          end
          M_RUN: begin
            if (stop_req) n_state = M_STOP;
          end
          default: n_state = M_STOP;
        endcase
      end
      m_stop   = (m_state != M_RUN);
      m_state  = n_state;
      d_bx0    = n_bx0;
      d_resync = n_resync;
      d_l1a    = l1a_in;
    end
  endtask

  task automatic check_outputs();
    compare(32'(bxn), 32'(m_bxn), "bxn");
    compare(32'(sync_err), 32'(m_err), "sync_err");
    compare(32'(trig_stop), 32'(m_stop), "trig_stop");
    compare(32'(tag.valid), 32'(m_tag_valid), "tag.valid");
    if (m_tag_valid) begin
      compare(32'(tag.bxn), 32'(m_tag_bxn), "tag.bxn");
    end
    compare(32'(l1a_count), 32'(m_count), "l1a_count");
  endtask

  // One clock cycle: model, drive, then check at the falling edge
  task automatic apply(input logic rst, input logic [7:0] c, input logic v, input logic l);
    @(posedge clock);
    model_step();
    reset     <= rst;
    cmd       <= c;
    cmd_valid <= v;
    l1a_in    <= l;
    ctrl      <= ctrl_set;
    @(negedge clock);
    check_outputs();
  endtask

  task automatic idle();
    apply(1'b0, 8'h00, 1'b0, 1'b0);
  endtask

  task automatic strobe(input logic [7:0] c);
    apply(1'b0, c, 1'b1, 1'b0);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset_wrap();
    int   errs;
    logic seen_wrap;
    bxn_t prev;
    errs      = errors;
    seen_wrap = 1'b0;
    repeat (10) apply(1'b1, 8'h00, 1'b0, 1'b0);
    idle();
    compare(32'(trig_stop), 32'd1, "trig_stop after reset");
    compare(32'(sync_err), 32'd0, "sync_err after reset");
    compare(32'(tag.valid), 32'd0, "tag.valid after reset");
    compare(32'(bxn), 32'd0, "bxn after reset");
    compare(32'(l1a_count), 32'd0, "l1a_count after reset");
    // Just over one orbit
    repeat (3700) begin
      prev = bxn;
      idle();
      if (prev == BX_MAX && bxn == 12'd0) seen_wrap = 1'b1;
    end
    compare(32'(seen_wrap), 32'd1, "bxn wrap from last crossing");
    end_test("reset_wrap", errs);
  endtask

  task automatic test_resync_load();
    int         errs;
    logic [7:0] code;
    errs = errors;
    repeat (30) begin
      code = pick_code();
      strobe(code);
      idle();
      idle();
      if (code == CMD_RESYNC || code == CMD_BCRESET) begin
        compare(32'(bxn), 32'(BXN_PRESET), "bxn preset two cycles after resync");
      end
      repeat (take_bits(3)) idle();
    end
    end_test("resync_load", errs);
  endtask

  task automatic test_bx0_alignment();
    int errs;
    int offset;
    errs = errors;
    repeat (8) begin
      // Offset 0 puts BX0 exactly on the preset
      offset = int'(take_bits(2));
      strobe(CMD_RESYNC);
      repeat (offset) idle();
      strobe(CMD_BX0);
      idle();
      idle();
      compare(32'(sync_err), 32'(offset != 0), "sync_err after BX0");
      repeat (20 + take_bits(4)) idle();
      compare(32'(sync_err), 32'(offset != 0), "sync_err held until resync");
    end
    end_test("bx0_alignment", errs);
  endtask

  task automatic test_fmm_random();
    int         errs;
    logic [3:0] r;
    logic [1:0] sel;
    logic       pending_bx0;
    errs        = errors;
    pending_bx0 = 1'b0;
    ctrl_set    = '0;
    // Resync then BX0 on the next strobe reaches run
    strobe(CMD_RESYNC);
    strobe(CMD_BX0);
    repeat (3) idle();
    compare(32'(trig_stop), 32'd0, "trig_stop low four cycles after resync");
    repeat (600) begin
      if (take_bits(4) == 0) begin
        sel = 2'(take_bits(2));
        case (sel)
          2'd0: ctrl_set.force_stop_trigger = ~ctrl_set.force_stop_trigger;
          2'd1: ctrl_set.ignore_startstop   = ~ctrl_set.ignore_startstop;
          2'd2: ctrl_set.dont_wait          = ~ctrl_set.dont_wait;
          default: ;
        endcase
      end
      if (pending_bx0) begin
        pending_bx0 = 1'b0;
        strobe(CMD_BX0);
      end else begin
        r = 4'(take_bits(4));
        case (r)
          4'd0: strobe(CMD_RESYNC);
          4'd1: begin
            strobe(CMD_RESYNC);
            pending_bx0 = 1'b1;
          end
          4'd2: strobe(CMD_BX0);
          4'd3: strobe(CMD_BCRESET);
          default: idle();
        endcase
      end
    end
    end_test("fmm_random", errs);
  endtask

  task automatic test_l1a_tagging();
    int errs;
    errs                        = errors;
    ctrl_set.ignore_startstop   = 1'b0;
    ctrl_set.force_stop_trigger = 1'b0;
    ctrl_set.dont_wait          = 1'b1;
    strobe(CMD_RESYNC);
    strobe(CMD_BX0);
    repeat (3) idle();
    // Half the cycles carry an L1A, so many come back to back
    repeat (400) begin
      if (take_bits(5) == 0) begin
        ctrl_set.force_stop_trigger = ~ctrl_set.force_stop_trigger;
      end
      apply(1'b0, 8'h00, 1'b0, 1'(take_bits(1)));
    end
    end_test("l1a_tagging", errs);
  endtask

  // --------------------------------------------------
  // Sequencer and watchdog
  // --------------------------------------------------
  initial begin
    reset        = 1'b1;
    cmd          = 8'h00;
    cmd_valid    = 1'b0;
    l1a_in       = 1'b0;
    ctrl         = '0;
    ctrl_set     = '0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_reset_wrap();
    test_resync_load();
    test_bx0_alignment();
    test_fmm_random();
    test_l1a_tagging();
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    int limit;
    limit = 1000;
    foreach (budget[i]) limit += budget[i];
    repeat (limit) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d clock cycles", limit);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire
